//--- project.f
design/csr_pkg.sv
design/priv_ctrl.sv
design/csr_regfile.sv
design/irq_arbiter.sv
design/csr_unit.sv
sim/csr_unit_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the CSR unit testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f --top-module csr_unit_tb \
    -o csr_unit_tb > build.log 2>&1 \
    && ./obj_dir/csr_unit_tb > sim.log 2>&1 \
    || { echo "Build or simulation did not complete, see build.log and sim.log"; exit 1; }

grep -q "SOME TESTS FAILED" sim.log && { echo "Simulation reported failures, see sim.log"; exit 1; }
echo "Simulation passed"
exit 0

//--- sim/csr_unit_tb.sv
`timescale 1ns/1ps

module csr_unit_tb import csr_pkg::*;;

    localparam int          reset_cycles   = 5;
    localparam int          cycles_per_row = 40;
    localparam word_t       pc_default     = 32'h0000_0100;
    localparam word_t       tvec_base      = 32'h0000_2000;
    // MXL 1 in bits 31:30 with I at bit 8 and M at bit 12
    localparam word_t       misa_expected  = 32'h4000_0000 | 32'h0000_1000 | 32'h0000_0100;
    localparam logic [63:0] cmp_value      = 64'h0000_0000_0000_0100;
    localparam logic [63:0] time_before    = 64'h0000_0000_0000_0010;
    localparam logic [63:0] time_after     = 64'h0000_0000_0000_0180;

    typedef struct packed {
        csr_cmd_t    cmd;
        logic [11:0] addr;
        word_t       operand;
        word_t       pc;
        logic        exc_valid;
        word_t       exc_cause;
        logic        ext_irq;
        logic        timer_hit;
        logic        chk_rdata;
        word_t       exp_rdata;
        logic        exp_redirect;
        word_t       exp_pc;
        priv_mode_t  exp_mode;
    } row_t;

    logic        clk;
    logic        rst_n;
    logic        req;
    csr_cmd_t    cmd;
    logic [11:0] addr;
    word_t       operand;
    word_t       pc;
    logic        exc_valid;
    word_t       exc_cause;
    logic        ext_irq;
    logic [63:0] mtime;
    logic [63:0] mtimecmp;
    logic        ack;
    word_t       rdata;
    logic        redirect;
    word_t       redirect_pc;
    priv_mode_t  mode;

    row_t        rows[$];
    logic [31:0] lfsr_state;
    logic        set_ext_irq;
    logic        set_timer;
    int          errors;
    int          checks;
    int          cycles;
    int          cycle_limit;
    int          row_idx;

    csr_unit csr_unit_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .req         (req),
        .cmd         (cmd),
        .addr        (addr),
        .operand     (operand),
        .pc          (pc),
        .exc_valid   (exc_valid),
        .exc_cause   (exc_cause),
        .ext_irq     (ext_irq),
        .mtime       (mtime),
        .mtimecmp    (mtimecmp),
        .ack         (ack),
        .rdata       (rdata),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .mode        (mode)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic random_word(output word_t w);
        int i;
        w = '0;
        for (i = 0; i < 32; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            w = {w[30:0], lfsr_state[0]};
        end
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL row %0d: %s = 0x%08h, expected 0x%08h", row_idx, name, got, exp);
        end
    endtask

    task automatic check_mode(input string name, input priv_mode_t got, input priv_mode_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL row %0d: %s = 0x%0h, expected 0x%0h", row_idx, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL row %0d: %s = 0x%0h, expected 0x%0h", row_idx, name, got, exp);
        end
    endtask

    task automatic add_row(input csr_cmd_t c, input logic [11:0] a, input word_t op,
                           input word_t p, input logic exc, input word_t cause,
                           input logic chk, input word_t exp_rd, input logic redir,
                           input word_t exp_pc, input priv_mode_t m);
        row_t r;
        r.cmd          = c;
        r.addr         = a;
        r.operand      = op;
        r.pc           = p;
        r.exc_valid    = exc;
        r.exc_cause    = cause;
        r.ext_irq      = set_ext_irq;
        r.timer_hit    = set_timer;
        r.chk_rdata    = chk;
        r.exp_rdata    = exp_rd;
        r.exp_redirect = redir;
        r.exp_pc       = exp_pc;
        r.exp_mode     = m;
        rows.push_back(r);
    endtask

    // Plain CSR access returns the old value on rdata
    task automatic add_csr_row(input csr_cmd_t c, input logic [11:0] a, input word_t op,
                               input word_t exp_rd, input priv_mode_t m);
        add_row(c, a, op, pc_default, 1'b0, '0, 1'b1, exp_rd, 1'b0, '0, m);
    endtask

    // Trap or MRET leaves rdata unchanged
    task automatic add_redirect_row(input csr_cmd_t c, input word_t p, input word_t exp_pc,
                                    input priv_mode_t m);
        add_row(c, MSCRATCH, '0, p, 1'b0, '0, 1'b0, '0, 1'b1, exp_pc, m);
    endtask

    task automatic build_table();
        word_t a;
        word_t b;
        word_t c;
        word_t scratch;
        random_word(a);
        random_word(b);
        random_word(c);
        scratch = (a | b) & ~c;
        set_ext_irq = 1'b0;
        set_timer   = 1'b0;

        // Read-modify-write on mscratch, mtvec, mepc and misa
        add_csr_row(CMD_WRITE, MSCRATCH, a, 32'h0, M_MODE);
        add_csr_row(CMD_SET, MSCRATCH, b, a, M_MODE);
        add_csr_row(CMD_CLEAR, MSCRATCH, c, a | b, M_MODE);
        add_csr_row(CMD_SET, MSCRATCH, 32'h0, scratch, M_MODE);
        add_csr_row(CMD_WRITE, MTVEC, tvec_base, 32'h0, M_MODE);
        add_csr_row(CMD_SET, MTVEC, 32'h0000_0100, tvec_base, M_MODE);
        add_csr_row(CMD_CLEAR, MTVEC, 32'h0000_0100, 32'h0000_2100, M_MODE);
        add_csr_row(CMD_SET, MTVEC, 32'h0, tvec_base, M_MODE);
        add_csr_row(CMD_WRITE, MEPC, 32'h0000_3007, 32'h0, M_MODE);
        add_csr_row(CMD_SET, MEPC, 32'h0, 32'h0000_3004, M_MODE);
        add_csr_row(CMD_SET, MISA, 32'h0, misa_expected, M_MODE);
        add_csr_row(CMD_WRITE, MISA, 32'h0, misa_expected, M_MODE);
        add_csr_row(CMD_SET, MISA, 32'h0, misa_expected, M_MODE);

        // ECALL from M and return with MPP = M
        add_redirect_row(CMD_ECALL, 32'h0000_0400, tvec_base, M_MODE);
        add_csr_row(CMD_SET, MCAUSE, 32'h0, 32'd11, M_MODE);
        add_csr_row(CMD_SET, MEPC, 32'h0, 32'h0000_0400, M_MODE);
        add_redirect_row(CMD_MRET, pc_default, 32'h0000_0400, M_MODE);

        // MPIE set and MPP back to U
        add_csr_row(CMD_SET, MSTATUS, 32'h0, 32'h0000_0080, M_MODE);
        add_csr_row(CMD_WRITE, MEPC, 32'h0000_0500, 32'h0000_0400, M_MODE);
        add_redirect_row(CMD_MRET, pc_default, 32'h0000_0500, U_MODE);
        add_csr_row(CMD_SET, MSCRATCH, 32'h0, 32'h0, U_MODE);
        add_csr_row(CMD_WRITE, MSCRATCH, 32'hdead_beef, 32'h0, U_MODE);
        add_redirect_row(CMD_ECALL, 32'h0000_0600, tvec_base, M_MODE);
        add_csr_row(CMD_SET, MCAUSE, 32'h0, 32'd8, M_MODE);
        add_csr_row(CMD_SET, MSCRATCH, 32'h0, scratch, M_MODE);

        // Vectored software interrupt taken from U
        add_csr_row(CMD_WRITE, MTVEC, tvec_base | 32'h1, tvec_base, M_MODE);
        add_csr_row(CMD_WRITE, MIE, 32'h0000_0008, 32'h0, M_MODE);
        add_csr_row(CMD_SET, MIP, 32'h0000_0008, 32'h0, M_MODE);
        add_redirect_row(CMD_MRET, pc_default, 32'h0000_0600, U_MODE);
        add_redirect_row(CMD_SET, 32'h0000_0700, tvec_base + 32'h0000_000c, M_MODE);
        add_csr_row(CMD_SET, MCAUSE, 32'h0, 32'h8000_0003, M_MODE);
        add_csr_row(CMD_SET, MIP, 32'h0, 32'h0, M_MODE);
        add_csr_row(CMD_SET, MEPC, 32'h0, 32'h0000_0700, M_MODE);

        // External and timer both pending and masked in M while MIE is clear
        add_csr_row(CMD_WRITE, MIE, 32'h0000_0880, 32'h0000_0008, M_MODE);
        set_ext_irq = 1'b1;
        set_timer   = 1'b1;
        add_csr_row(CMD_SET, MIP, 32'h0, 32'h0000_0880, M_MODE);
        add_redirect_row(CMD_MRET, pc_default, 32'h0000_0700, U_MODE);
        set_ext_irq = 1'b0;
        add_redirect_row(CMD_SET, 32'h0000_0800, tvec_base + 32'h0000_002c, M_MODE);
        add_csr_row(CMD_SET, MCAUSE, 32'h0, 32'h8000_000b, M_MODE);
        add_csr_row(CMD_SET, MIP, 32'h0, 32'h0000_0080, M_MODE);
        add_redirect_row(CMD_MRET, pc_default, 32'h0000_0800, U_MODE);
        add_redirect_row(CMD_SET, 32'h0000_0840, tvec_base + 32'h0000_001c, M_MODE);
        set_timer = 1'b0;
        add_csr_row(CMD_SET, MCAUSE, 32'h0, 32'h8000_0007, M_MODE);
        add_csr_row(CMD_WRITE, MIE, 32'h0, 32'h0000_0880, M_MODE);

        // Core exception wins over the write in the same request
        add_row(CMD_WRITE, MSCRATCH, 32'h1234_5678, 32'h0000_0900, 1'b1, 32'd2,
                1'b0, '0, 1'b1, tvec_base, M_MODE);
        add_csr_row(CMD_SET, MSCRATCH, 32'h0, scratch, M_MODE);
        add_csr_row(CMD_SET, MCAUSE, 32'h0, 32'd2, M_MODE);
        add_csr_row(CMD_SET, MEPC, 32'h0, 32'h0000_0900, M_MODE);
    endtask

    task automatic apply_row(input row_t r);
        ext_irq = r.ext_irq;
        mtime   = r.timer_hit ? time_after : time_before;
        // meip and mtip settle one edge after their inputs
        @(posedge clk);
        #1;
        cmd       = r.cmd;
        addr      = r.addr;
        operand   = r.operand;
        pc        = r.pc;
        exc_valid = r.exc_valid;
        exc_cause = r.exc_cause;
        req       = 1'b1;
        @(posedge clk);
        #1;
        // Commit and ack share the first edge
        check_bit("ack", ack, 1'b1);
        while (!ack) begin
            @(posedge clk);
            #1;
        end
        check_mode("mode", mode, r.exp_mode);
        check_bit("redirect", redirect, r.exp_redirect);
        if (r.chk_rdata) begin
            check_word("rdata", rdata, r.exp_rdata);
        end
        if (r.exp_redirect) begin
            check_word("redirect_pc", redirect_pc, r.exp_pc);
        end
        req = 1'b0;
        @(posedge clk);
        #1;
        // First edge with req low drops ack
        check_bit("ack", ack, 1'b0);
        while (ack) begin
            @(posedge clk);
            #1;
        end
        exc_valid = 1'b0;
    endtask

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("Timeout: handshake still open after %0d cycles", cycles);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    initial begin
        rst_n      = 1'b0;
        req        = 1'b0;
        cmd        = CMD_NONE;
        addr       = '0;
        operand    = '0;
        pc         = '0;
        exc_valid  = 1'b0;
        exc_cause  = '0;
        ext_irq    = 1'b0;
        mtime      = time_before;
        mtimecmp   = cmp_value;
        errors     = 0;
        checks     = 0;
        cycles     = 0;
        row_idx    = 0;
        lfsr_state = 32'heab8d1d2;
        build_table();
        cycle_limit = rows.size() * cycles_per_row + reset_cycles;

        repeat (reset_cycles) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // Idle outputs straight out of reset
        check_bit("ack", ack, 1'b0);
        check_bit("redirect", redirect, 1'b0);
        check_word("rdata", rdata, 32'h0);
        check_mode("mode", mode, M_MODE);

        for (row_idx = 0; row_idx < rows.size(); row_idx++) begin
            apply_row(rows[row_idx]);
        end

        $display("Summary: %0d rows, %0d checks, %0d errors", rows.size(), checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- design/csr_unit.sv
`timescale 1ns/1ps

module csr_unit import csr_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        req,
    input  csr_cmd_t    cmd,
    input  logic [11:0] addr,
    input  word_t       operand,
    input  word_t       pc,
    input  logic        exc_valid,
    input  word_t       exc_cause,
    input  logic        ext_irq,
    input  logic [63:0] mtime,
    input  logic [63:0] mtimecmp,
    output logic        ack,
    output word_t       rdata,
    output logic        redirect,
    output word_t       redirect_pc,
    output priv_mode_t  mode
);

    logic       csr_op_en;
    logic       trap_en;
    word_t      trap_cause;
    word_t      trap_epc;
    logic       irq_take;
    word_t      mstatus_word;
    logic       mstatus_wr;
    logic       mie_wr;
    logic       mip_wr;
    word_t      wdata;
    word_t      mtvec;
    word_t      mepc;
    logic       irq_pending;
    logic [3:0] irq_code;
    word_t      mie_bits;
    word_t      mip_bits;

    priv_ctrl priv_ctrl_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .req          (req),
        .ack          (ack),
        .cmd          (cmd),
        .pc           (pc),
        .exc_valid    (exc_valid),
        .exc_cause    (exc_cause),
        .irq_pending  (irq_pending),
        .irq_code     (irq_code),
        .mtvec        (mtvec),
        .mepc         (mepc),
        .mstatus_wr   (mstatus_wr),
        .wdata        (wdata),
        .csr_op_en    (csr_op_en),
        .trap_en      (trap_en),
        .trap_cause   (trap_cause),
        .trap_epc     (trap_epc),
        .irq_take     (irq_take),
        .mstatus_word (mstatus_word),
        .redirect     (redirect),
        .redirect_pc  (redirect_pc),
        .mode         (mode)
    );

    csr_regfile csr_regfile_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .csr_op_en    (csr_op_en),
        .cmd          (cmd),
        .addr         (addr),
        .operand      (operand),
        .mode         (mode),
        .trap_en      (trap_en),
        .trap_cause   (trap_cause),
        .trap_epc     (trap_epc),
        .mstatus_word (mstatus_word),
        .mie_bits     (mie_bits),
        .mip_bits     (mip_bits),
        .rdata        (rdata),
        .wdata        (wdata),
        .mstatus_wr   (mstatus_wr),
        .mie_wr       (mie_wr),
        .mip_wr       (mip_wr),
        .mtvec        (mtvec),
        .mepc         (mepc)
    );

    irq_arbiter irq_arbiter_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .ext_irq     (ext_irq),
        .mtime       (mtime),
        .mtimecmp    (mtimecmp),
        .mie_wr      (mie_wr),
        .mip_wr      (mip_wr),
        .wdata       (wdata),
        .irq_take    (irq_take),
        .irq_pending (irq_pending),
        .irq_code    (irq_code),
        .mie_bits    (mie_bits),
        .mip_bits    (mip_bits)
    );

endmodule

//--- design/irq_arbiter.sv
`timescale 1ns/1ps

module irq_arbiter import csr_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        ext_irq,
    input  logic [63:0] mtime,
    input  logic [63:0] mtimecmp,
    input  logic        mie_wr,
    input  logic        mip_wr,
    input  word_t       wdata,
    input  logic        irq_take,
    output logic        irq_pending,
    output logic [3:0]  irq_code,
    output word_t       mie_bits,
    output word_t       mip_bits
);

    logic meie;
    logic msie;
    logic mtie;
    logic meip;
    logic msip;
    logic mtip;
    logic mei_ready;
    logic msi_ready;
    logic mti_ready;

    assign mei_ready = meip && meie;
    assign msi_ready = msip && msie;
    assign mti_ready = mtip && mtie;

    // MEI > MSI > MTI
    assign irq_pending = mei_ready || msi_ready || mti_ready;
    assign irq_code    = mei_ready ? cause_irq_mei[3:0] :
                         msi_ready ? cause_irq_msi[3:0] :
                         mti_ready ? cause_irq_mti[3:0] : 4'd0;

    always_comb begin
        mie_bits = '0;
        mie_bits[meip_bit] = meie;
        mie_bits[msip_bit] = msie;
        mie_bits[mtip_bit] = mtie;
        mip_bits = '0;
        mip_bits[meip_bit] = meip;
        mip_bits[msip_bit] = msip;
        mip_bits[mtip_bit] = mtip;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            meie <= 1'b0;
            msie <= 1'b0;
            mtie <= 1'b0;
        end else if (mie_wr) begin
            meie <= wdata[meip_bit];
            msie <= wdata[msip_bit];
            mtie <= wdata[mtip_bit];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            meip <= 1'b0;
            msip <= 1'b0;
            mtip <= 1'b0;
        end else begin
            // Timer level, one cycle behind mtime
            mtip <= (mtime >= mtimecmp);
            if (ext_irq) begin
                meip <= 1'b1;
            end else if (irq_take && mei_ready) begin
                meip <= 1'b0;
            end
            if (irq_take && !mei_ready && msi_ready) begin
                msip <= 1'b0;
            end else if (mip_wr) begin
                msip <= wdata[msip_bit];
            end
        end
    end

    take_when_pending: assert property (
        @(posedge clk) disable iff (!rst_n) irq_take |-> irq_pending
    );

endmodule

//--- design/csr_regfile.sv
`timescale 1ns/1ps

module csr_regfile import csr_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        csr_op_en,
    input  csr_cmd_t    cmd,
    input  logic [11:0] addr,
    input  word_t       operand,
    input  priv_mode_t  mode,
    input  logic        trap_en,
    input  word_t       trap_cause,
    input  word_t       trap_epc,
    input  word_t       mstatus_word,
    input  word_t       mie_bits,
    input  word_t       mip_bits,
    output word_t       rdata,
    output word_t       wdata,
    output logic        mstatus_wr,
    output logic        mie_wr,
    output logic        mip_wr,
    output word_t       mtvec,
    output word_t       mepc
);

    word_t     mscratch;
    word_t     mcause;
    word_t     rd_value;
    csr_addr_t csr_sel;
    logic      can_read;
    logic      can_write;
    logic      is_write;
    logic      write_ok;

    assign csr_sel = csr_addr_t'(addr);

    // Bits 9:8 hold the lowest mode allowed, 11:10 == 3 marks read-only
    assign can_read  = (addr[9:8] <= mode);
    assign can_write = can_read && (addr[11:10] != 2'b11);
    assign is_write  = cmd inside {CMD_WRITE, CMD_SET, CMD_CLEAR};
    assign write_ok  = csr_op_en && can_write && is_write;

    always_comb begin
        rd_value = '0;
        if (can_read) begin
            case (csr_sel)
                MSTATUS:  rd_value = mstatus_word;
                MISA:     rd_value = misa_value;
                MIE:      rd_value = mie_bits;
                MTVEC:    rd_value = mtvec;
                MSCRATCH: rd_value = mscratch;
                MEPC:     rd_value = mepc;
                MCAUSE:   rd_value = mcause;
                MIP:      rd_value = mip_bits;
                default:  rd_value = '0;
            endcase
        end
    end

    always_comb begin
        case (cmd)
            CMD_WRITE: wdata = operand;
            CMD_SET:   wdata = rd_value | operand;
            CMD_CLEAR: wdata = rd_value & ~operand;
            default:   wdata = rd_value;
        endcase
    end

    // State kept in priv_ctrl and irq_arbiter
    assign mstatus_wr = write_ok && (csr_sel == MSTATUS);
    assign mie_wr     = write_ok && (csr_sel == MIE);
    assign mip_wr     = write_ok && (csr_sel == MIP);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mtvec    <= '0;
            mscratch <= '0;
            mepc     <= '0;
            mcause   <= '0;
        end else if (trap_en) begin
            mcause <= trap_cause;
            mepc   <= {trap_epc[xlen-1:2], 2'b00};
        end else if (write_ok) begin
            case (csr_sel)
                MTVEC:    mtvec    <= wdata;
                MSCRATCH: mscratch <= wdata;
                // IALIGN is 32, low bits stay zero
                MEPC:     mepc     <= {wdata[xlen-1:2], 2'b00};
                MCAUSE:   mcause   <= wdata;
                default: begin
                end
            endcase
        end
    end

    // Old value, before the write on the same edge
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rdata <= '0;
        end else if (csr_op_en) begin
            rdata <= rd_value;
        end
    end

    op_trap_exclusive: assert property (
        @(posedge clk) disable iff (!rst_n) !(csr_op_en && trap_en)
    );

endmodule

//--- design/priv_ctrl.sv
`timescale 1ns/1ps

module priv_ctrl import csr_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       req,
    output logic       ack,
    input  csr_cmd_t   cmd,
    input  word_t      pc,
    input  logic       exc_valid,
    input  word_t      exc_cause,
    input  logic       irq_pending,
    input  logic [3:0] irq_code,
    input  word_t      mtvec,
    input  word_t      mepc,
    input  logic       mstatus_wr,
    input  word_t      wdata,
    output logic       csr_op_en,
    output logic       trap_en,
    output word_t      trap_cause,
    output word_t      trap_epc,
    output logic       irq_take,
    output word_t      mstatus_word,
    output logic       redirect,
    output word_t      redirect_pc,
    output priv_mode_t mode
);

    logic       mstatus_mie;
    logic       mstatus_mpie;
    priv_mode_t mstatus_mpp;

    logic       commit;
    logic       is_ecall;
    logic       irq_fire;
    logic       is_mret;
    word_t      tvec_base;
    word_t      trap_target;

    // First edge with req high and ack low
    assign commit = req && !ack;

    // U mode always takes interrupts, M mode only with MIE set
    assign irq_fire = irq_pending && (mode == U_MODE || mstatus_mie);
    assign is_ecall = (cmd == CMD_ECALL);

    // Exception, then ECALL, then interrupt
    assign trap_en   = commit && (exc_valid || is_ecall || irq_fire);
    assign irq_take  = trap_en && !exc_valid && !is_ecall;
    assign is_mret   = commit && !trap_en && (cmd == CMD_MRET);
    assign csr_op_en = commit && !trap_en && (cmd != CMD_MRET);

    assign trap_cause = exc_valid ? exc_cause :
                        is_ecall  ? ((mode == U_MODE) ? cause_ecall_u : cause_ecall_m) :
                                    (irq_flag | {{(xlen-4){1'b0}}, irq_code});
    assign trap_epc   = pc;

    // Vectored mode only offsets interrupts
    assign tvec_base   = {mtvec[xlen-1:2], 2'b00};
    assign trap_target = (irq_take && mtvec[1:0] == tvec_vectored) ?
                         tvec_base + {{(xlen-6){1'b0}}, irq_code, 2'b00} : tvec_base;

    always_comb begin
        mstatus_word = '0;
        mstatus_word[mstatus_mie_bit]       = mstatus_mie;
        mstatus_word[mstatus_mpie_bit]      = mstatus_mpie;
        mstatus_word[mstatus_mpp_lsb +: 2]  = mstatus_mpp;
    end

    // Four-phase handshake, ack held until req drops
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack <= 1'b0;
        end else if (!req) begin
            ack <= 1'b0;
        end else if (commit) begin
            ack <= 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mode         <= M_MODE;
            mstatus_mie  <= 1'b0;
            mstatus_mpie <= 1'b0;
            mstatus_mpp  <= U_MODE;
            redirect     <= 1'b0;
        end else begin
            if (commit) begin
                redirect <= trap_en || is_mret;
            end
            if (trap_en) begin
                mstatus_mpie <= mstatus_mie;
                mstatus_mie  <= 1'b0;
                mstatus_mpp  <= mode;
                mode         <= M_MODE;
            end else if (is_mret) begin
                mstatus_mie  <= mstatus_mpie;
                mstatus_mpie <= 1'b1;
                mode         <= mstatus_mpp;
                mstatus_mpp  <= U_MODE;
            end else if (mstatus_wr) begin
                mstatus_mie  <= wdata[mstatus_mie_bit];
                mstatus_mpie <= wdata[mstatus_mpie_bit];
                // MPP is WARL, anything but M reads back as U
                mstatus_mpp  <= (wdata[mstatus_mpp_lsb +: 2] == M_MODE) ? M_MODE : U_MODE;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (trap_en) begin
            redirect_pc <= trap_target;
        end else if (is_mret) begin
            redirect_pc <= mepc;
        end
    end

    ack_needs_req: assert property (
        @(posedge clk) disable iff (!rst_n) $rose(ack) |-> $past(req)
    );

    mpp_legal: assert property (
        @(posedge clk) disable iff (!rst_n) mstatus_mpp inside {U_MODE, M_MODE}
    );

endmodule

//--- design/csr_pkg.sv
package csr_pkg;

    localparam int xlen = 32;

    typedef logic [xlen-1:0] word_t;

    // Only U and M are implemented, S encoding left out
    typedef enum logic [1:0] {
        U_MODE = 2'd0,
        M_MODE = 2'd3
    } priv_mode_t;

    typedef enum logic [2:0] {
        CMD_NONE  = 3'd0,
        CMD_WRITE = 3'd1,
        CMD_SET   = 3'd2,
        CMD_CLEAR = 3'd3,
        CMD_ECALL = 3'd4,
        CMD_MRET  = 3'd5
    } csr_cmd_t;

    typedef enum logic [11:0] {
        MSTATUS  = 12'h300,
        MISA     = 12'h301,
        MIE      = 12'h304,
        MTVEC    = 12'h305,
        MSCRATCH = 12'h340,
        MEPC     = 12'h341,
        MCAUSE   = 12'h342,
        MIP      = 12'h344
    } csr_addr_t;

    // MXL = 1 (32 bit), extensions I and M
    localparam word_t misa_value = 32'h4000_1100;

    // Exception causes
    localparam word_t cause_ecall_u = 32'd8;
    localparam word_t cause_ecall_m = 32'd11;

    // Interrupt causes, combined with irq_flag in mcause
    localparam word_t cause_irq_msi = 32'd3;
    localparam word_t cause_irq_mti = 32'd7;
    localparam word_t cause_irq_mei = 32'd11;
    localparam word_t irq_flag      = 32'h8000_0000;

    // mstatus fields
    localparam int mstatus_mie_bit  = 3;
    localparam int mstatus_mpie_bit = 7;
    localparam int mstatus_mpp_lsb  = 11;

    // Shared by mie and mip
    localparam int msip_bit = 3;
    localparam int mtip_bit = 7;
    localparam int meip_bit = 11;

    localparam logic [1:0] tvec_vectored = 2'b01;

endpackage
